// File: verilog/core_pkg.sv
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [4:0]  opcode_t;
  typedef logic [2:0]  funct3_t;

  // major opcodes, instr[6:2]
  localparam opcode_t OP_LUI    = 5'b01101;
  localparam opcode_t OP_AUIPC  = 5'b00101;
  localparam opcode_t OP_JAL    = 5'b11011;
  localparam opcode_t OP_JALR   = 5'b11001;
  localparam opcode_t OP_BRANCH = 5'b11000;
  localparam opcode_t OP_LOAD   = 5'b00000;
  localparam opcode_t OP_STORE  = 5'b01000;
  localparam opcode_t OP_CALRI  = 5'b00100;
  localparam opcode_t OP_CALRR  = 5'b01100;
  localparam opcode_t OP_SYS    = 5'b11100;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  // branch funct3
  localparam funct3_t BR_BEQ  = 3'b000;
  localparam funct3_t BR_BNE  = 3'b001;
  localparam funct3_t BR_BLT  = 3'b100;
  localparam funct3_t BR_BGE  = 3'b101;
  localparam funct3_t BR_BLTU = 3'b110;
  localparam funct3_t BR_BGEU = 3'b111;

endpackage

// File: verilog/csr_pkg.sv
package csr_pkg;

  typedef logic [11:0] csr_addr_t;

  // machine csrs held by the core
  localparam csr_addr_t CSR_MTVEC  = 12'h305;
  localparam csr_addr_t CSR_MEPC   = 12'h341;
  localparam csr_addr_t CSR_MCAUSE = 12'h342;

  // environment call from M-mode
  localparam logic [31:0] CAUSE_ECALL = 32'd11;

endpackage

// File: verilog/core_ifs.sv
`timescale 1ns/1ps

// decoded instruction, one per valid/ready transfer
interface exec_if import core_pkg::*, csr_pkg::*; ();
  logic      valid;
  logic      ready;
  word_t     pc, src1, src2, imm, csr_rdata, alu_a, alu_b;
  opcode_t   opcode;
  funct3_t   funct;
  reg_idx_t  rd;
  csr_addr_t csr_addr;
  alu_op_t   alu_op;

  modport decode (
    output valid, pc, opcode, funct, rd, src1, src2, imm, csr_addr, csr_rdata,
           alu_a, alu_b, alu_op,
    input  ready
  );
  modport execute (
    input  valid, pc, opcode, funct, rd, src1, src2, imm, csr_addr, csr_rdata,
           alu_a, alu_b, alu_op,
    output ready
  );
endinterface

// data memory, request and response channels
interface mem_if import core_pkg::*; ();
  logic    req_valid, req_ready, we, resp_valid, resp_ready;
  word_t   addr, wdata, rdata;
  funct3_t size;

  modport requester (
    output req_valid, we, addr, size, wdata, resp_ready,
    input  req_ready, resp_valid, rdata
  );
  modport memory (
    input  req_valid, we, addr, size, wdata, resp_ready,
    output req_ready, resp_valid, rdata
  );
endinterface

// writeback, taken by result on every retire pulse
interface wb_if import core_pkg::*, csr_pkg::*; ();
  logic      retire, gpr_wen, csr_wen1, csr_wen2;
  word_t     pc, gpr_wdata, csr_wdata1, csr_wdata2;
  reg_idx_t  rd;
  csr_addr_t csr_addr1, csr_addr2;

  modport source (
    output retire, pc, gpr_wen, rd, gpr_wdata,
           csr_wen1, csr_addr1, csr_wdata1, csr_wen2, csr_addr2, csr_wdata2
  );
  modport sink (
    input  retire, pc, gpr_wen, rd, gpr_wdata,
           csr_wen1, csr_addr1, csr_wdata1, csr_wen2, csr_addr2, csr_wdata2
  );
endinterface

// register and csr read ports
interface rf_if import core_pkg::*, csr_pkg::*; ();
  reg_idx_t  rs1, rs2;
  csr_addr_t csr_addr;
  word_t     rdata1, rdata2, csr_rdata;

  modport reader (output rs1, rs2, csr_addr, input rdata1, rdata2, csr_rdata);
  modport provider (input rs1, rs2, csr_addr, output rdata1, rdata2, csr_rdata);
endinterface

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu import core_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_t op,
  output word_t   y
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;
      ALU_SLL:  y = a << shamt;
      ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: y = {31'b0, a < b};
      ALU_XOR:  y = a ^ b;
      ALU_SRL:  y = a >> shamt;
      // sign bit fills from the left
      ALU_SRA:  y = $signed(a) >>> shamt;
      ALU_OR:   y = a | b;
      ALU_AND:  y = a & b;
      default:  y = '0;
    endcase
  end

endmodule

// File: verilog/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import core_pkg::*, csr_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic   clk,
  input  logic   rstn,
  input  logic   instr_valid,
  output logic   instr_ready,
  input  word_t  instr,
  output word_t  pc,
  input  word_t  npc,
  exec_if.decode ex,
  rf_if.reader   rf
);

  opcode_t opcode;
  funct3_t funct;
  word_t   imm;
  word_t   src1;
  word_t   csr_rdata;
  alu_op_t calc_op;

  assign opcode    = instr[6:2];
  assign funct     = instr[14:12];
  assign src1      = rf.rdata1;
  assign csr_rdata = rf.csr_rdata;

  assign rf.rs1 = instr[19:15];
  assign rf.rs2 = instr[24:20];

  // ecall needs mtvec and mret needs mepc as jump target
  always_comb begin
    if (opcode == OP_SYS && funct == 3'b000) begin
      rf.csr_addr = instr[21] ? CSR_MEPC : CSR_MTVEC;
    end else begin
      rf.csr_addr = instr[31:20];
    end
  end

  always_comb begin
    case (opcode)
      OP_LUI, OP_AUIPC: imm = {instr[31:12], 12'b0};
      OP_JAL:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      OP_BRANCH: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      OP_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      default:   imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  // instr[30] picks sub and sra
  always_comb begin
    case (funct)
      3'b000:  calc_op = (opcode == OP_CALRR && instr[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  calc_op = ALU_SLL;
      3'b010:  calc_op = ALU_SLT;
      3'b011:  calc_op = ALU_SLTU;
      3'b100:  calc_op = ALU_XOR;
      3'b101:  calc_op = instr[30] ? ALU_SRA : ALU_SRL;
      3'b110:  calc_op = ALU_OR;
      default: calc_op = ALU_AND;
    endcase
  end

  always_comb begin
    ex.alu_a  = src1;
    ex.alu_b  = imm;
    ex.alu_op = ALU_ADD;
    case (opcode)
      OP_LUI:   ex.alu_a = '0;
      OP_AUIPC: ex.alu_a = pc;
      OP_JAL, OP_JALR: begin
        // link address
        ex.alu_a = pc;
        ex.alu_b = 32'd4;
      end
      OP_BRANCH: begin
        ex.alu_b = rf.rdata2;
        case (funct)
          BR_BEQ, BR_BNE: ex.alu_op = ALU_SUB;
          BR_BLT, BR_BGE: ex.alu_op = ALU_SLT;
          default:        ex.alu_op = ALU_SLTU;
        endcase
      end
      OP_CALRI: ex.alu_op = calc_op;
      OP_CALRR: begin
        ex.alu_b  = rf.rdata2;
        ex.alu_op = calc_op;
      end
      OP_SYS: begin
        // new csr value from old value and rs1
        ex.alu_a = csr_rdata;
        ex.alu_b = src1;
        case (funct)
          3'b001: ex.alu_a = '0;
          3'b010: ex.alu_op = ALU_OR;
          default: begin
            ex.alu_b  = ~src1;
            ex.alu_op = ALU_AND;
          end
        endcase
      end
      default: ;
    endcase
  end

  assign instr_ready  = ex.ready;
  assign ex.valid     = instr_valid;
  assign ex.pc        = pc;
  assign ex.opcode    = opcode;
  assign ex.funct     = funct;
  assign ex.rd        = instr[11:7];
  assign ex.src1      = src1;
  assign ex.src2      = rf.rdata2;
  assign ex.imm       = imm;
  assign ex.csr_addr  = instr[31:20];
  assign ex.csr_rdata = csr_rdata;

  always_ff @(posedge clk) begin
    if (rstn) begin
      pc <= RESET_PC;
    end else if (instr_valid && ex.ready) begin
      pc <= npc;
    end
  end

endmodule

// File: verilog/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import core_pkg::*, csr_pkg::*; (
  input  logic     clk,
  input  logic     rstn,
  exec_if.execute  ex,
  output word_t    npc,
  mem_if.requester mem,
  wb_if.source     wb
);

  typedef enum logic [1:0] {EX_IDLE, EX_REQ, EX_RESP, EX_WB} ex_state_t;

  ex_state_t state;
  word_t     alu_y, gpr_wdata_d;
  logic      accept, is_mem, ecall, csr_op, zero, br_taken, gpr_wen_d;
  logic      ready_q, gpr_wen_q, csr_wen1_q, csr_wen2_q, we_q;
  word_t     pc_q, gpr_wdata_q, csr_wdata1_q, addr_q, wdata_q;
  reg_idx_t  rd_q;
  csr_addr_t csr_addr1_q;
  funct3_t   size_q;

  alu u_alu (.a(ex.alu_a), .b(ex.alu_b), .op(ex.alu_op), .y(alu_y));

  assign accept = ex.valid && ready_q;
  assign is_mem = (ex.opcode == OP_LOAD) || (ex.opcode == OP_STORE);
  assign ecall  = (ex.opcode == OP_SYS) && (ex.funct == 3'b000) && (ex.csr_addr == '0);
  assign csr_op = (ex.opcode == OP_SYS) && (ex.funct != 3'b000);
  assign zero   = (alu_y == '0);

  always_comb begin
    case (ex.funct)
      BR_BEQ:          br_taken = zero;
      BR_BNE:          br_taken = !zero;
      BR_BLT, BR_BLTU: br_taken = alu_y[0];
      BR_BGE, BR_BGEU: br_taken = !alu_y[0];
      default:         br_taken = 1'b0;
    endcase
  end

  // ecall and mret arrive with mtvec or mepc in csr_rdata
  always_comb begin
    case (ex.opcode)
      OP_JAL:    npc = ex.pc + ex.imm;
      OP_JALR:   npc = (ex.src1 + ex.imm) & ~32'd1;
      OP_BRANCH: npc = br_taken ? ex.pc + ex.imm : ex.pc + 32'd4;
      OP_SYS:    npc = (ex.funct == 3'b000) ? ex.csr_rdata : ex.pc + 32'd4;
      default:   npc = ex.pc + 32'd4;
    endcase
  end

  always_comb begin
    case (ex.opcode)
      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
      OP_LOAD, OP_CALRI, OP_CALRR: gpr_wen_d = 1'b1;
      OP_SYS:                      gpr_wen_d = csr_op;
      default:                     gpr_wen_d = 1'b0;
    endcase
  end
  assign gpr_wdata_d = csr_op ? ex.csr_rdata : alu_y;

  always_ff @(posedge clk) begin
    if (rstn) begin
      state      <= EX_IDLE;
      ready_q    <= 1'b1;
      gpr_wen_q  <= 1'b0;
      csr_wen1_q <= 1'b0;
      csr_wen2_q <= 1'b0;
    end else begin
      case (state)
        EX_IDLE: begin
          if (accept) begin
            ready_q    <= 1'b0;
            gpr_wen_q  <= gpr_wen_d;
            csr_wen1_q <= csr_op || ecall;
            csr_wen2_q <= ecall;
            state      <= is_mem ? EX_REQ : EX_WB;
          end
        end
        EX_REQ:  state <= mem.req_ready ? EX_RESP : EX_REQ;
        EX_RESP: state <= mem.resp_valid ? EX_WB : EX_RESP;
        default: begin
          state   <= EX_IDLE;
          ready_q <= 1'b1;
        end
      endcase
    end
  end

  // writeback and request payload
  always_ff @(posedge clk) begin
    if (accept) begin
      pc_q         <= ex.pc;
      rd_q         <= ex.rd;
      gpr_wdata_q  <= gpr_wdata_d;
      csr_addr1_q  <= ecall ? CSR_MEPC : ex.csr_addr;
      csr_wdata1_q <= ecall ? ex.pc : alu_y;
      we_q         <= (ex.opcode == OP_STORE);
      addr_q       <= alu_y;
      size_q       <= ex.funct;
      wdata_q      <= ex.src2;
    end else if (mem.resp_valid && mem.resp_ready) begin
      gpr_wdata_q <= mem.rdata;
    end
  end

  assign ex.ready       = ready_q;
  assign mem.req_valid  = (state == EX_REQ);
  assign mem.we         = we_q;
  assign mem.addr       = addr_q;
  assign mem.size       = size_q;
  assign mem.wdata      = wdata_q;
  assign mem.resp_ready = (state == EX_RESP);

  assign wb.retire     = (state == EX_WB);
  assign wb.pc         = pc_q;
  assign wb.gpr_wen    = wb.retire && gpr_wen_q;
  assign wb.rd         = rd_q;
  assign wb.gpr_wdata  = gpr_wdata_q;
  assign wb.csr_wen1   = wb.retire && csr_wen1_q;
  assign wb.csr_addr1  = csr_addr1_q;
  assign wb.csr_wdata1 = csr_wdata1_q;
  assign wb.csr_wen2   = wb.retire && csr_wen2_q;
  assign wb.csr_addr2  = CSR_MCAUSE;
  assign wb.csr_wdata2 = CAUSE_ECALL;

  a_req_hold: assert property (@(posedge clk) disable iff (rstn)
    mem.req_valid && !mem.req_ready |=> mem.req_valid && $stable(mem.addr) &&
      $stable(mem.we) && $stable(mem.size) && $stable(mem.wdata));

  a_busy_not_ready: assert property (@(posedge clk) disable iff (rstn)
    state != EX_IDLE |-> !ex.ready);

endmodule

// File: verilog/result_unit.sv
`timescale 1ns/1ps

module result_unit import core_pkg::*, csr_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  wb_if.sink         wb,
  rf_if.provider     rf,
  output logic       retire_valid,
  output word_t      retire_pc,
  output reg_idx_t   retire_rd,
  output word_t      retire_wdata
);

  word_t gpr [32];
  word_t mepc, mcause, mtvec;
  logic  show_rd;

  // x0 is never written and reads as zero
  always_ff @(posedge clk) begin
    if (wb.retire && wb.gpr_wen && wb.rd != '0) begin
      gpr[wb.rd] <= wb.gpr_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      mepc   <= '0;
      mcause <= '0;
      mtvec  <= '0;
    end else if (wb.retire) begin
      if (wb.csr_wen1) begin
        case (wb.csr_addr1)
          CSR_MEPC:   mepc   <= wb.csr_wdata1;
          CSR_MCAUSE: mcause <= wb.csr_wdata1;
          CSR_MTVEC:  mtvec  <= wb.csr_wdata1;
          default: ;
        endcase
      end
      // second port only carries the trap cause
      if (wb.csr_wen2) begin
        case (wb.csr_addr2)
          CSR_MEPC:   mepc   <= wb.csr_wdata2;
          CSR_MCAUSE: mcause <= wb.csr_wdata2;
          CSR_MTVEC:  mtvec  <= wb.csr_wdata2;
          default: ;
        endcase
      end
    end
  end

  assign rf.rdata1 = (rf.rs1 == '0) ? '0 : gpr[rf.rs1];
  assign rf.rdata2 = (rf.rs2 == '0) ? '0 : gpr[rf.rs2];

  always_comb begin
    case (rf.csr_addr)
      CSR_MEPC:   rf.csr_rdata = mepc;
      CSR_MCAUSE: rf.csr_rdata = mcause;
      CSR_MTVEC:  rf.csr_rdata = mtvec;
      default:    rf.csr_rdata = '0;
    endcase
  end

  assign show_rd      = wb.gpr_wen && (wb.rd != '0);
  assign retire_valid = wb.retire;
  assign retire_pc    = wb.pc;
  assign retire_rd    = show_rd ? wb.rd : '0;
  assign retire_wdata = show_rd ? wb.gpr_wdata : '0;

  a_retire_gap: assert property (@(posedge clk) disable iff (rstn)
    wb.retire |=> !wb.retire);

endmodule

// File: verilog/data_mem.sv
`timescale 1ns/1ps

module data_mem import core_pkg::*; #(
  parameter int MEM_WORDS   = 256,
  parameter int MEM_LATENCY = 2
) (
  input  logic  clk,
  input  logic  rstn,
  mem_if.memory mem
);

  localparam int AW = $clog2(MEM_WORDS);
  localparam int CW = $clog2(MEM_LATENCY + 1);

  word_t         ram [MEM_WORDS] = '{default: '0};
  logic [AW-1:0] idx;
  logic [4:0]    lane;
  logic [3:0]    be;
  word_t         raw, wshift, load_val, rdata_q;
  logic          busy;
  logic [CW-1:0] count;

  // word index wraps with the memory size
  assign idx    = mem.addr[AW+1:2];
  assign lane   = {mem.addr[1:0], 3'b000};
  assign raw    = ram[idx] >> lane;
  assign wshift = mem.wdata << lane;

  always_comb begin
    case (mem.size[1:0])
      2'b00:   be = 4'b0001 << mem.addr[1:0];
      2'b01:   be = 4'b0011 << mem.addr[1:0];
      default: be = 4'b1111;
    endcase
  end

  // size[2] set means zero extension
  always_comb begin
    case (mem.size[1:0])
      2'b00:   load_val = mem.size[2] ? {24'b0, raw[7:0]} : {{24{raw[7]}}, raw[7:0]};
      2'b01:   load_val = mem.size[2] ? {16'b0, raw[15:0]} : {{16{raw[15]}}, raw[15:0]};
      default: load_val = raw;
    endcase
  end

  always_ff @(posedge clk) begin
    if (mem.req_valid && mem.req_ready) begin
      rdata_q <= load_val;
      if (mem.we) begin
        for (int b = 0; b < 4; b++) begin
          if (be[b]) begin
            ram[idx][8*b +: 8] <= wshift[8*b +: 8];
          end
        end
      end
    end
  end

  // countdown to response
  always_ff @(posedge clk) begin
    if (rstn) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (mem.req_valid && mem.req_ready) begin
      busy  <= 1'b1;
      count <= CW'(MEM_LATENCY - 1);
    end else if (mem.resp_valid && mem.resp_ready) begin
      busy <= 1'b0;
    end else if (busy && count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign mem.req_ready  = !busy;
  assign mem.resp_valid = busy && (count == '0);
  assign mem.rdata      = rdata_q;

  // requester waits for the pending response before the next request
  a_no_req_pending: assert property (@(posedge clk) disable iff (rstn)
    busy |-> !mem.req_valid);

endmodule

// File: verilog/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top import core_pkg::*; #(
  parameter word_t RESET_PC    = '0,
  parameter int    MEM_WORDS   = 256,
  parameter int    MEM_LATENCY = 2
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     instr_valid,
  output logic     instr_ready,
  input  word_t    instr,
  output word_t    pc,
  output logic     retire_valid,
  output word_t    retire_pc,
  output reg_idx_t retire_rd,
  output word_t    retire_wdata
);

  exec_if ex_bus ();
  mem_if  mem_bus ();
  wb_if   wb_bus ();
  rf_if   rf_bus ();

  word_t npc;

  decode_unit #(.RESET_PC(RESET_PC)) u_decode (
    .clk(clk), .rstn(rstn), .instr_valid(instr_valid), .instr_ready(instr_ready),
    .instr(instr), .pc(pc), .npc(npc), .ex(ex_bus), .rf(rf_bus)
  );

  execute_unit u_execute (
    .clk(clk), .rstn(rstn), .ex(ex_bus), .npc(npc), .mem(mem_bus), .wb(wb_bus)
  );

  result_unit u_result (
    .clk(clk), .rstn(rstn), .wb(wb_bus), .rf(rf_bus),
    .retire_valid(retire_valid), .retire_pc(retire_pc),
    .retire_rd(retire_rd), .retire_wdata(retire_wdata)
  );

  data_mem #(.MEM_WORDS(MEM_WORDS), .MEM_LATENCY(MEM_LATENCY)) u_dmem (
    .clk(clk), .rstn(rstn), .mem(mem_bus)
  );

endmodule

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core import core_pkg::*, csr_pkg::*; ();

  localparam word_t RESET_PC    = 32'h0;
  localparam int    MEM_WORDS   = 256;
  localparam int    MEM_LATENCY = 2;
  localparam int    SEED        = 32'h6f88;

  logic     clk, rstn, instr_valid, instr_ready, retire_valid, xfer, done;
  word_t    instr, pc, retire_pc, retire_wdata;
  reg_idx_t retire_rd;

  word_t prog [$];
  string tags [$];
  word_t xr [32];
  word_t mem_m [MEM_WORDS];
  word_t mepc_m, mcause_m, mtvec_m, m_pc, end_pc;
  int    retired, accepted, cycles, limit;

  rv_core_top #(.RESET_PC(RESET_PC), .MEM_WORDS(MEM_WORDS), .MEM_LATENCY(MEM_LATENCY)) dut (
    .clk(clk), .rstn(rstn), .instr_valid(instr_valid), .instr_ready(instr_ready),
    .instr(instr), .pc(pc), .retire_valid(retire_valid), .retire_pc(retire_pc),
    .retire_rd(retire_rd), .retire_wdata(retire_wdata)
  );

  always #5 clk = ~clk;

  // instruction encoders
  function automatic word_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_CALRR, 2'b11};
  endfunction
  function automatic word_t enc_i(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                  opcode_t op);
    return {imm, 5'(rs1), f3, 5'(rd), op, 2'b11};
  endfunction
  function automatic word_t enc_s(logic [11:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], OP_STORE, 2'b11};
  endfunction
  function automatic word_t enc_b(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], OP_BRANCH, 2'b11};
  endfunction
  function automatic word_t enc_u(logic [19:0] imm, int rd, opcode_t op);
    return {imm, 5'(rd), op, 2'b11};
  endfunction
  function automatic word_t enc_j(logic [20:0] imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), OP_JAL, 2'b11};
  endfunction

  task automatic emit(word_t w, string tag);
    prog.push_back(w);
    tags.push_back(tag);
  endtask

  task automatic load_reg(int rd, word_t v, string tag);
    emit(enc_u(v[31:12], rd, OP_LUI), tag);
    emit(enc_i(v[11:0], rd, 3'b000, rd, OP_CALRI), tag);
  endtask

  task automatic build_program();
    int k;
    logic [2:0] ifn [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
    logic [2:0] bfn [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    // registers start undefined in the core
    for (int r = 1; r < 16; r++) emit(enc_i(12'h0, 0, 3'b000, r, OP_CALRI), "init");
    for (int n = 0; n < 3; n++) begin
      load_reg(1, $urandom, "arith");
      load_reg(2, $urandom, "arith");
      for (int f = 0; f < 8; f++) emit(enc_r(7'h00, 2, 1, 3'(f), 3), "arith_op");
      emit(enc_r(7'h20, 2, 1, 3'd0, 3), "arith_sub");
      emit(enc_r(7'h20, 2, 1, 3'd5, 3), "arith_sra");
      foreach (ifn[i]) emit(enc_i(12'($urandom), 1, ifn[i], 4, OP_CALRI), "arith_imm");
      emit(enc_i({7'h00, 5'($urandom)}, 1, 3'd1, 4, OP_CALRI), "arith_slli");
      emit(enc_i({7'h00, 5'($urandom)}, 1, 3'd5, 4, OP_CALRI), "arith_srli");
      emit(enc_i({7'h20, 5'($urandom)}, 1, 3'd5, 4, OP_CALRI), "arith_srai");
      emit(enc_r(7'h00, 2, 1, 3'd0, 0), "arith_x0");
    end
    // each branch skips one increment when taken
    load_reg(1, $urandom, "branch");
    load_reg(2, $urandom, "branch");
    foreach (bfn[i]) begin
      emit(enc_b(13'd8, 2, 1, bfn[i]), "branch_diff");
      emit(enc_i(12'd1, 4, 3'd0, 4, OP_CALRI), "branch_skip");
      emit(enc_b(13'd8, 1, 2, bfn[i]), "branch_swap");
      emit(enc_i(12'd1, 4, 3'd0, 4, OP_CALRI), "branch_skip");
      emit(enc_b(13'd8, 1, 1, bfn[i]), "branch_same");
      emit(enc_i(12'd1, 4, 3'd0, 4, OP_CALRI), "branch_skip");
    end
    emit(enc_j(21'd8, 1), "jal");
    emit(enc_i(12'd1, 4, 3'd0, 4, OP_CALRI), "jal_skip");
    emit(enc_u(20'h0, 3, OP_AUIPC), "auipc");
    emit(enc_i(12'd13, 3, 3'd0, 4, OP_JALR), "jalr_odd");
    emit(enc_i(12'd1, 6, 3'd0, 6, OP_CALRI), "jalr_skip");
    emit(enc_u(20'($urandom), 5, OP_LUI), "lui");
    for (int n = 0; n < 2; n++) begin
      emit(enc_i({2'b00, 8'($urandom), 2'b00}, 0, 3'd0, 10, OP_CALRI), "mem_base");
      load_reg(11, $urandom, "mem_data");
      emit(enc_s(12'd0, 11, 10, 3'd2), "sw");
      emit(enc_s(12'd6, 11, 10, 3'd1), "sh");
      emit(enc_s(12'd9, 11, 10, 3'd0), "sb");
      emit(enc_i(12'd0, 10, 3'd2, 12, OP_LOAD), "lw");
      emit(enc_i(12'd2, 10, 3'd1, 12, OP_LOAD), "lh");
      emit(enc_i(12'd6, 10, 3'd5, 12, OP_LOAD), "lhu");
      emit(enc_i(12'd4, 10, 3'd1, 12, OP_LOAD), "lh_store");
      emit(enc_i(12'd9, 10, 3'd0, 12, OP_LOAD), "lb");
      emit(enc_i(12'd9, 10, 3'd4, 12, OP_LOAD), "lbu");
      emit(enc_i(12'd3, 10, 3'd0, 12, OP_LOAD), "lb_hi");
      emit(enc_i(12'd8, 10, 3'd2, 12, OP_LOAD), "lw_next");
    end
    load_reg(1, $urandom, "csr");
    load_reg(2, $urandom, "csr");
    emit(enc_i(CSR_MTVEC, 1, 3'd1, 7, OP_SYS), "csrrw");
    emit(enc_i(CSR_MTVEC, 2, 3'd2, 8, OP_SYS), "csrrs");
    emit(enc_i(CSR_MTVEC, 2, 3'd3, 9, OP_SYS), "csrrc");
    // handler sits right behind the jump over it
    k = prog.size();
    emit(enc_i(12'((k + 4) * 4), 0, 3'd0, 12, OP_CALRI), "trap_vec");
    emit(enc_i(CSR_MTVEC, 12, 3'd1, 0, OP_SYS), "trap_vec");
    emit(32'h0000_0073, "ecall");
    emit(enc_j(21'd24, 0), "trap_return");
    emit(enc_i(CSR_MEPC, 0, 3'd2, 5, OP_SYS), "read_mepc");
    emit(enc_i(CSR_MCAUSE, 0, 3'd2, 6, OP_SYS), "read_mcause");
    emit(enc_i(12'd4, 5, 3'd0, 5, OP_CALRI), "trap_handler");
    emit(enc_i(CSR_MEPC, 5, 3'd1, 0, OP_SYS), "trap_handler");
    emit(32'h3020_0073, "mret");
    emit(enc_i(CSR_MTVEC, 0, 3'd2, 13, OP_SYS), "after_mret");
  endtask

  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // architectural step of the instruction at the model pc
  function automatic void model_step(output word_t e_pc, output reg_idx_t e_rd,
                                     output word_t e_wd);
    word_t ins, a, b, imm_i, imm_s, imm_b, imm_j, nxt, wd, addr, w, msk, old;
    logic [2:0] f3;
    logic wen, taken;
    int idx;
    ins   = prog[m_pc >> 2];
    f3    = ins[14:12];
    a     = xr[ins[19:15]];
    b     = xr[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    nxt   = m_pc + 4;
    wd    = '0;
    wen   = 1'b1;
    addr  = a + ((ins[6:2] == OP_STORE) ? imm_s : imm_i);
    idx   = (addr >> 2) % MEM_WORDS;
    case (ins[6:2])
      OP_LUI:   wd = {ins[31:12], 12'h0};
      OP_AUIPC: wd = m_pc + {ins[31:12], 12'h0};
      OP_JAL: begin
        wd  = m_pc + 4;
        nxt = m_pc + imm_j;
      end
      OP_JALR: begin
        wd  = m_pc + 4;
        nxt = (a + imm_i) & 32'hffff_fffe;
      end
      OP_BRANCH: begin
        wen = 1'b0;
        case (f3)
          3'd0: taken = (a == b);
          3'd1: taken = (a != b);
          3'd4: taken = $signed(a) < $signed(b);
          3'd5: taken = $signed(a) >= $signed(b);
          3'd6: taken = a < b;
          default: taken = a >= b;
        endcase
        if (taken) nxt = m_pc + imm_b;
      end
      OP_LOAD: begin
        w = mem_m[idx] >> (8 * addr[1:0]);
        case (f3)
          3'd0: wd = {{24{w[7]}}, w[7:0]};
          3'd1: wd = {{16{w[15]}}, w[15:0]};
          3'd4: wd = {24'h0, w[7:0]};
          3'd5: wd = {16'h0, w[15:0]};
          default: wd = w;
        endcase
      end
      OP_STORE: begin
        wen = 1'b0;
        msk = (f3 == 3'd0) ? 32'hff : (f3 == 3'd1) ? 32'hffff : 32'hffff_ffff;
        msk = msk << (8 * addr[1:0]);
        mem_m[idx] = (mem_m[idx] & ~msk) | ((b << (8 * addr[1:0])) & msk);
      end
      OP_CALRI: wd = alu_ref(f3, (f3 == 3'd5) && ins[30], a, imm_i);
      OP_CALRR: wd = alu_ref(f3, ins[30], a, b);
      default: begin
        if (f3 == 3'd0) begin
          wen = 1'b0;
          if (ins[21]) begin
            nxt = mepc_m;
          end else begin
            mepc_m   = m_pc;
            mcause_m = 32'd11;
            nxt      = mtvec_m;
          end
        end else begin
          case (ins[31:20])
            CSR_MEPC:   old = mepc_m;
            CSR_MCAUSE: old = mcause_m;
            CSR_MTVEC:  old = mtvec_m;
            default:    old = '0;
          endcase
          wd = old;
          w  = (f3 == 3'd1) ? a : (f3 == 3'd2) ? (old | a) : (old & ~a);
          case (ins[31:20])
            CSR_MEPC:   mepc_m = w;
            CSR_MCAUSE: mcause_m = w;
            CSR_MTVEC:  mtvec_m = w;
            default: ;
          endcase
        end
      end
    endcase
    e_pc = m_pc;
    e_rd = (wen && ins[11:7] != 0) ? ins[11:7] : 5'd0;
    e_wd = (e_rd != 0) ? wd : '0;
    if (e_rd != 0) xr[e_rd] = wd;
    m_pc = nxt;
  endfunction

  task automatic check(string name, word_t exp, word_t act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // instruction supply, a pending word stays until taken
  always @(posedge clk) begin
    xfer <= rstn ? 1'b0 : (instr_valid && instr_ready);
    if (!rstn && instr_valid && instr_ready) begin
      accepted++;
    end
  end

  always @(negedge clk) begin
    if (rstn) begin
      instr_valid <= 1'b0;
    end else if (!instr_valid || xfer) begin
      if ((pc >> 2) < prog.size() && ($urandom % 4) != 0) begin
        instr_valid <= 1'b1;
        instr       <= prog[pc >> 2];
      end else begin
        instr_valid <= 1'b0;
        instr       <= '0;
      end
    end
  end

  always @(negedge clk) begin
    word_t    e_pc, e_wd;
    reg_idx_t e_rd;
    if (!rstn && retire_valid) begin
      if (m_pc >= end_pc) begin
        $display("an instruction retired after the program had ended");
        $display("STATUS: FAIL");
        $fatal(1, "extra retire");
      end else begin
        model_step(e_pc, e_rd, e_wd);
        check({tags[e_pc >> 2], " pc"}, e_pc, retire_pc);
        check({tags[e_pc >> 2], " rd"}, 32'(e_rd), 32'(retire_rd));
        check({tags[e_pc >> 2], " wdata"}, e_wd, retire_wdata);
        retired++;
        if (m_pc == end_pc) done = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout, the program did not finish within %0d cycles", limit);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    clk         = 1'b0;
    rstn        = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    done        = 1'b0;
    retired     = 0;
    accepted    = 0;
    cycles      = 0;
    limit       = 1000000;
    void'($urandom(SEED));
    build_program();
    end_pc = RESET_PC + 4 * prog.size();
    limit  = prog.size() * (2 + MEM_LATENCY + 2) + 200;
    foreach (xr[i]) xr[i] = '0;
    foreach (mem_m[i]) mem_m[i] = '0;
    mepc_m   = '0;
    mcause_m = '0;
    mtvec_m  = '0;
    m_pc     = RESET_PC;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstn = 1'b0;
    check("reset pc", RESET_PC, pc);
    check("reset retire", 32'd0, 32'(retire_valid));
    check("reset ready", 32'd1, 32'(instr_ready));
    wait (done);
    repeat (MEM_LATENCY + 6) @(negedge clk);
    check("final pc", end_pc, pc);
    // every accepted instruction retires exactly once
    check("retire count", 32'(accepted), 32'(retired));
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: all.f
verilog/core_pkg.sv
verilog/csr_pkg.sv
verilog/core_ifs.sv
verilog/alu.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/result_unit.sv
verilog/data_mem.sv
verilog/rv_core_top.sv
testbench/tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_rv_core \
  -f all.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0
